//--- hw/clmul_pkg.sv
// ----------------------------------------
// Shared widths, FIFO depths, register map,
// mode codes and the job record for the
// carry-less multiply accelerator.
// ----------------------------------------

package clmul_pkg;

  localparam int XLEN      = 32;  // Operand and result width.
  localparam int JOB_DEPTH = 4;
  localparam int RES_DEPTH = 4;
  localparam int ADDR_W    = 5;   // AXI4-Lite address width.

  // ----------------------------------------
  // Register map
  // ----------------------------------------
  localparam logic [ADDR_W-1:0] REG_OPA    = 5'h00;
  localparam logic [ADDR_W-1:0] REG_OPB    = 5'h04;
  localparam logic [ADDR_W-1:0] REG_CMD    = 5'h08;  // Write only, mode in bits 1:0.
  localparam logic [ADDR_W-1:0] REG_RESULT = 5'h0C;  // Read pops one result.
  localparam logic [ADDR_W-1:0] REG_STATUS = 5'h10;  // Bit 0 result ready, bit 1 queue full.

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef enum logic [1:0] {
    MODE_CLMUL  = 2'd0,  // Low word of the product.
    MODE_CLMULH = 2'd1,  // High word of the product.
    MODE_CLMULR = 2'd2   // Bits 62:31 of the product.
  } clmul_mode_e;

  localparam logic [1:0] MODE_RSVD = 2'd3;

  typedef struct packed {
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    clmul_mode_e     mode;
  } clmul_job_t;

endpackage

//--- hw/poly16_mul.sv
// ----------------------------------------
// 16x16 carry-less multiplier, purely
// combinational, 32-bit product.
// ----------------------------------------

`timescale 1ns/100ps

module poly16_mul (
  input  logic [15:0] a,
  input  logic [15:0] b,
  output logic [31:0] r
);

  logic [31:0] a_ext;

  assign a_ext = {16'b0, a};

  // Shift-and-XOR over the bits of b. Highest reachable bit is 30.
  always_comb begin
    r = '0;
    for (int i = 0; i < 16; i++) begin
      if (b[i]) begin
        r = r ^ (a_ext << i);
      end
    end
  end

endmodule

//--- hw/clmul_fifo.sv
// ----------------------------------------
// Synchronous FIFO with a type parameter
// for the payload and a depth parameter.
// ----------------------------------------

`timescale 1ns/100ps

module clmul_fifo #(
  parameter type T     = logic [31:0],
  parameter int  DEPTH = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  logic push,
  input  T     push_data,
  output logic full,
  input  logic pop,
  output T     pop_data,
  output logic empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T             mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  assign full     = (count == CNT_W'(DEPTH));
  assign empty    = (count == '0);
  assign pop_data = mem[rd_ptr];  // Head entry, valid while not empty.

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(push) - CNT_W'(pop);  // Push and pop together keep the count.
    end
  end

  // ----------------------------------------
  // Protocol checks
  // ----------------------------------------
  a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);
  a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

endmodule

//--- hw/clmul_engine.sv
// ----------------------------------------
// Two-stage Karatsuba 32x32 carry-less
// multiplier with mode select and stall.
// ----------------------------------------

`timescale 1ns/100ps

module clmul_engine import clmul_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            in_valid,
  output logic            in_ready,
  input  clmul_job_t      in_job,
  output logic            out_valid,
  input  logic            out_ready,
  output logic [XLEN-1:0] out_data
);

  logic            stall;
  logic [15:0]     a_mid;
  logic [15:0]     b_mid;
  logic [31:0]     p_lo;
  logic [31:0]     p_hi;
  logic [31:0]     p_mid;

  logic            s1_valid;
  logic [31:0]     s1_lo;
  logic [31:0]     s1_hi;
  logic [31:0]     s1_mid;
  clmul_mode_e     s1_mode;

  logic [31:0]     mid_sum;
  logic [63:0]     prod;
  logic [XLEN-1:0] sel_data;

  // Output held and not taken freezes both stages.
  assign stall    = out_valid & ~out_ready;
  assign in_ready = ~stall;

  // ----------------------------------------
  // Stage 1: three half-width products
  // ----------------------------------------
  assign a_mid = in_job.op_a[31:16] ^ in_job.op_a[15:0];
  assign b_mid = in_job.op_b[31:16] ^ in_job.op_b[15:0];

  poly16_mul u_mul_lo  (.a(in_job.op_a[15:0]),  .b(in_job.op_b[15:0]),  .r(p_lo));
  poly16_mul u_mul_hi  (.a(in_job.op_a[31:16]), .b(in_job.op_b[31:16]), .r(p_hi));
  poly16_mul u_mul_mid (.a(a_mid),              .b(b_mid),              .r(p_mid));

  always_ff @(posedge clk) begin
    if (!stall && in_valid) begin
      s1_lo   <= p_lo;
      s1_hi   <= p_hi;
      s1_mid  <= p_mid;
      s1_mode <= in_job.mode;
    end
  end

  // ----------------------------------------
  // Stage 2: recombine and select the window
  // ----------------------------------------
  assign mid_sum = s1_mid ^ s1_lo ^ s1_hi;
  assign prod    = {s1_hi, s1_lo} ^ {16'b0, mid_sum, 16'b0};

  always_comb begin
    case (s1_mode)
      MODE_CLMUL:  sel_data = prod[31:0];
      MODE_CLMULH: sel_data = prod[63:32];
      MODE_CLMULR: sel_data = prod[62:31];
      default:     sel_data = prod[31:0];
    endcase
  end

  always_ff @(posedge clk) begin
    if (!stall && s1_valid) begin
      out_data <= sel_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else if (!stall) begin
      s1_valid  <= in_valid;
      out_valid <= s1_valid;
    end
  end

  // The register block filters the reserved code before it reaches the queue.
  a_no_rsvd_mode : assert property (@(posedge clk) disable iff (!rst_n)
    (in_valid && in_ready) |-> (in_job.mode != MODE_RSVD));

endmodule

//--- hw/clmul_regs.sv
// ----------------------------------------
// AXI4-Lite register block: operands,
// command push and result pop.
// ----------------------------------------

`timescale 1ns/100ps

module clmul_regs import clmul_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  // AXI4-Lite write channels.
  input  logic [ADDR_W-1:0] awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  logic [XLEN-1:0]   wdata,
  input  logic [3:0]        wstrb,    // Full-word writes only.
  input  logic              wvalid,
  output logic              wready,
  output logic [1:0]        bresp,
  output logic              bvalid,
  input  logic              bready,
  // AXI4-Lite read channels.
  input  logic [ADDR_W-1:0] araddr,
  input  logic              arvalid,
  output logic              arready,
  output logic [XLEN-1:0]   rdata,
  output logic [1:0]        rresp,
  output logic              rvalid,
  input  logic              rready,
  // Job and result queues.
  output logic              job_push,
  output clmul_job_t        job_data,
  input  logic              job_full,
  output logic              res_pop,
  input  logic [XLEN-1:0]   res_data,
  input  logic              res_empty
);

  logic [XLEN-1:0] opa_q;
  logic [XLEN-1:0] opb_q;
  logic            wr_hs;
  logic            rd_hs;
  logic [1:0]      wr_resp;
  logic [1:0]      rd_resp;
  logic [XLEN-1:0] rd_data;

  assign wr_hs = awready & awvalid & wvalid;
  assign rd_hs = arready & arvalid;

  assign job_data.op_a = opa_q;
  assign job_data.op_b = opb_q;
  assign job_data.mode = clmul_mode_e'(wdata[1:0]);

  // ----------------------------------------
  // Write decode
  // ----------------------------------------
  always_comb begin
    wr_resp  = RESP_OKAY;
    job_push = 1'b0;
    case (awaddr)
      REG_OPA, REG_OPB: wr_resp = RESP_OKAY;
      REG_CMD: begin
        if (wdata[1:0] == MODE_RSVD || job_full) begin
          wr_resp = RESP_SLVERR;  // Nothing is queued.
        end else begin
          job_push = wr_hs;
        end
      end
      default: wr_resp = RESP_SLVERR;
    endcase
  end

  // ----------------------------------------
  // Read decode
  // ----------------------------------------
  always_comb begin
    rd_data = '0;
    rd_resp = RESP_OKAY;
    res_pop = 1'b0;
    case (araddr)
      REG_OPA: rd_data = opa_q;
      REG_OPB: rd_data = opb_q;
      REG_RESULT: begin
        if (res_empty) begin
          rd_resp = RESP_SLVERR;
        end else begin
          rd_data = res_data;
          res_pop = rd_hs;
        end
      end
      REG_STATUS: rd_data = {{(XLEN-2){1'b0}}, job_full, ~res_empty};
      default: rd_resp = RESP_SLVERR;  // CMD is write only.
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      arready <= 1'b0;
      rvalid  <= 1'b0;
      opa_q   <= '0;
      opb_q   <= '0;
    end else begin
      // Single-cycle ready pulses, one transaction outstanding per direction.
      awready <= awvalid & wvalid & ~bvalid & ~awready;
      wready  <= awvalid & wvalid & ~bvalid & ~awready;
      arready <= arvalid & ~rvalid & ~arready;
      if (wr_hs) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      if (rd_hs) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
      if (wr_hs && awaddr == REG_OPA) begin
        opa_q <= wdata;
      end
      if (wr_hs && awaddr == REG_OPB) begin
        opb_q <= wdata;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_hs) begin
      bresp <= wr_resp;
    end
    if (rd_hs) begin
      rdata <= rd_data;
      rresp <= rd_resp;
    end
  end

  // ----------------------------------------
  // Response channel checks
  // ----------------------------------------
  a_bvalid_hold : assert property (@(posedge clk) disable iff (!rst_n)
    (bvalid && !bready) |=> bvalid);
  a_rvalid_hold : assert property (@(posedge clk) disable iff (!rst_n)
    (rvalid && !rready) |=> (rvalid && $stable(rdata)));

endmodule

//--- hw/clmul_top.sv
// ----------------------------------------
// Accelerator top: register block, job
// FIFO, multiply engine and result FIFO.
// ----------------------------------------

`timescale 1ns/100ps

module clmul_top import clmul_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [ADDR_W-1:0] awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  logic [XLEN-1:0]   wdata,
  input  logic [3:0]        wstrb,
  input  logic              wvalid,
  output logic              wready,
  output logic [1:0]        bresp,
  output logic              bvalid,
  input  logic              bready,
  input  logic [ADDR_W-1:0] araddr,
  input  logic              arvalid,
  output logic              arready,
  output logic [XLEN-1:0]   rdata,
  output logic [1:0]        rresp,
  output logic              rvalid,
  input  logic              rready
);

  logic            job_push;
  clmul_job_t      job_data;
  logic            job_full;
  logic            job_empty;
  clmul_job_t      eng_job;
  logic            eng_in_ready;
  logic            eng_out_valid;
  logic [XLEN-1:0] eng_out_data;
  logic            res_full;
  logic            res_pop;
  logic [XLEN-1:0] res_data;
  logic            res_empty;

  clmul_regs u_regs (
    .clk, .rst_n,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .job_push, .job_data, .job_full,
    .res_pop, .res_data, .res_empty
  );

  clmul_fifo #(.T(clmul_job_t), .DEPTH(JOB_DEPTH)) u_job_fifo (
    .clk, .rst_n,
    .push(job_push), .push_data(job_data), .full(job_full),
    .pop(~job_empty & eng_in_ready), .pop_data(eng_job), .empty(job_empty)
  );

  clmul_engine u_engine (
    .clk, .rst_n,
    .in_valid(~job_empty), .in_ready(eng_in_ready), .in_job(eng_job),
    .out_valid(eng_out_valid), .out_ready(~res_full), .out_data(eng_out_data)
  );

  clmul_fifo #(.T(logic [XLEN-1:0]), .DEPTH(RES_DEPTH)) u_res_fifo (
    .clk, .rst_n,
    .push(eng_out_valid & ~res_full), .push_data(eng_out_data), .full(res_full),
    .pop(res_pop), .pop_data(res_data), .empty(res_empty)
  );

endmodule

//--- test/tb_clmul.sv
// ----------------------------------------
// Testbench for the carry-less multiply
// accelerator: AXI4-Lite tasks, xorshift
// stimulus, reference model and watchdog.
// ----------------------------------------

`timescale 1ns/100ps

module tb_clmul import clmul_pkg::*; ();

  localparam int NUM_RANDOM     = 200;
  localparam int BURST_LEN      = 16;
  localparam int NUM_EDGE       = 5;
  localparam int TOTAL_JOBS     = NUM_RANDOM + BURST_LEN + 1 + NUM_EDGE * NUM_EDGE * 3;
  localparam int TIMEOUT_CYCLES = 300 * TOTAL_JOBS + 1000;

  logic              clk;
  logic              rst_n;
  logic [ADDR_W-1:0] awaddr;
  logic              awvalid;
  logic              awready;
  logic [XLEN-1:0]   wdata;
  logic [3:0]        wstrb;
  logic              wvalid;
  logic              wready;
  logic [1:0]        bresp;
  logic              bvalid;
  logic              bready;
  logic [ADDR_W-1:0] araddr;
  logic              arvalid;
  logic              arready;
  logic [XLEN-1:0]   rdata;
  logic [1:0]        rresp;
  logic              rvalid;
  logic              rready;

  logic [31:0] rng_state;
  logic [31:0] expected [$];  // Model results in job order.
  int          num_checks;
  int          num_errors;

  clmul_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ----------------------------------------
  // Stimulus and model helpers
  // ----------------------------------------
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Bitwise GF(2) product, then the Zbc window for the mode.
  function automatic logic [31:0] model_result(input logic [31:0] a, input logic [31:0] b,
                                               input logic [1:0] mode);
    logic [63:0] prod;
    prod = '0;
    for (int i = 0; i < 32; i++) begin
      if (b[i]) begin
        prod = prod ^ ({32'b0, a} << i);
      end
    end
    case (mode)
      2'd1:    return prod[63:32];
      2'd2:    return prod[62:31];
      default: return prod[31:0];
    endcase
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    num_checks++;
    if (got !== exp) begin
      num_errors++;
      $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // ----------------------------------------
  // AXI4-Lite tasks, entered and left on a falling edge
  // ----------------------------------------
  task automatic axi_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(negedge clk);
    while (!awready) @(negedge clk);
    check_eq(32'(wready), 32'd1, "wready together with awready");
    @(negedge clk);  // Handshake edge has passed.
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) @(negedge clk);
    resp   = bresp;
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [ADDR_W-1:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(negedge clk);
    arvalid = 1'b0;
    while (!rvalid) @(negedge clk);
    data   = rdata;
    resp   = rresp;
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic write_ok(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
    logic [1:0] resp;
    axi_write(addr, data, resp);
    check_eq(32'(resp), 32'(RESP_OKAY), $sformatf("write response at %h", addr));
  endtask

  // Poll STATUS bit 0 until a result is waiting.
  task automatic wait_result();
    logic [31:0] status;
    logic [1:0]  resp;
    axi_read(REG_STATUS, status, resp);
    while (status[0] !== 1'b1) axi_read(REG_STATUS, status, resp);
  endtask

  task automatic drain_and_check(input string what);
    logic [31:0] data;
    logic [1:0]  resp;
    while (expected.size() > 0) begin
      wait_result();
      axi_read(REG_RESULT, data, resp);
      check_eq(data, expected.pop_front(), what);
      check_eq(32'(resp), 32'(RESP_OKAY), {what, " response"});
    end
  endtask

  task automatic run_job(input logic [31:0] a, input logic [31:0] b, input logic [1:0] mode);
    write_ok(REG_OPA, a);
    write_ok(REG_OPB, b);
    write_ok(REG_CMD, {30'b0, mode});
    expected.push_back(model_result(a, b, mode));
    drain_and_check($sformatf("result a=%h b=%h mode=%0d", a, b, mode));
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] data;
    logic [1:0]  mode;
    logic [1:0]  resp;
    logic        saw_slverr;
    logic [31:0] edge_vals [NUM_EDGE];

    rng_state  = 32'h6f78_bb69;
    num_checks = 0;
    num_errors = 0;
    rst_n   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = 4'hF;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Operand registers read back.
    for (int i = 0; i < 8; i++) begin
      a = next_rand();
      b = next_rand();
      write_ok(REG_OPA, a);
      write_ok(REG_OPB, b);
      axi_read(REG_OPA, data, resp);
      check_eq(data, a, "OPA readback");
      check_eq(32'(resp), 32'(RESP_OKAY), "OPA read response");
      axi_read(REG_OPB, data, resp);
      check_eq(data, b, "OPB readback");
      check_eq(32'(resp), 32'(RESP_OKAY), "OPB read response");
    end

    for (int i = 0; i < NUM_RANDOM; i++) begin
      a    = next_rand();
      b    = next_rand();
      mode = 2'(next_rand() % 32'd3);
      run_job(a, b, mode);
    end

    // Burst of commands with no result reads in between.
    saw_slverr = 1'b0;
    for (int i = 0; i < BURST_LEN; i++) begin
      a    = next_rand();
      b    = next_rand();
      mode = 2'(next_rand() % 32'd3);
      write_ok(REG_OPA, a);
      write_ok(REG_OPB, b);
      axi_write(REG_CMD, {30'b0, mode}, resp);
      if (resp == RESP_OKAY) begin
        expected.push_back(model_result(a, b, mode));
      end else begin
        check_eq(32'(resp), 32'(RESP_SLVERR), "burst CMD response");
        saw_slverr = 1'b1;
        axi_read(REG_STATUS, data, resp);
        check_eq(32'(data[1]), 32'd1, "STATUS bit 1 with job queue full");
      end
    end
    check_eq(32'(saw_slverr), 32'd1, "SLVERR seen during burst");
    drain_and_check("burst result");

    // Reserved mode, then an empty RESULT read.
    axi_write(REG_CMD, 32'd3, resp);
    check_eq(32'(resp), 32'(RESP_SLVERR), "reserved mode response");
    repeat (20) @(negedge clk);
    axi_read(REG_STATUS, data, resp);
    check_eq(32'(data[0]), 32'd0, "STATUS bit 0 with nothing pending");
    axi_read(REG_RESULT, data, resp);
    check_eq(data, 32'd0, "empty RESULT data");
    check_eq(32'(resp), 32'(RESP_SLVERR), "empty RESULT response");

    edge_vals[0] = 32'h0000_0000;
    edge_vals[1] = 32'hffff_ffff;
    edge_vals[2] = 32'h0000_0001;
    edge_vals[3] = 32'h8000_0000;
    edge_vals[4] = 32'h0000_8000;  // Crosses the Karatsuba half boundary.
    for (int i = 0; i < NUM_EDGE; i++) begin
      for (int j = 0; j < NUM_EDGE; j++) begin
        for (int m = 0; m < 3; m++) begin
          run_job(edge_vals[i], edge_vals[j], 2'(m));
        end
      end
    end

    $display("Checks: %0d, errors: %0d", num_checks, num_errors);
    if (num_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Checks: %0d, errors: %0d", num_checks, num_errors);
    $display("** FAIL **");
    $finish;
  end

endmodule

//--- build.f
hw/clmul_pkg.sv
hw/poly16_mul.sv
hw/clmul_fifo.sv
hw/clmul_engine.sv
hw/clmul_regs.sv
hw/clmul_top.sv
test/tb_clmul.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_clmul
FILELIST = build.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -qF "** PASS **" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
